/* hdl/conv_pkg.sv */
`default_nettype none

package conv_pkg;

  //////////////////////////////
  // array geometry
  //////////////////////////////

  // rows of systolic arrays in the core
  localparam int sa_row_num = 4;
  // output rows drained from each array
  localparam int row_num_in_sa = 16;
  // one bias set per output row of every array
  localparam int bias_sets_num = sa_row_num * row_num_in_sa;
  // output channels per processing element
  localparam int pe_parallel_weight = 2;

  //////////////////////////////
  // bias widths
  //////////////////////////////

  localparam int bias_width = 8;
  // two lane biases side by side, lane 0 in the low byte
  localparam int bias_set_width = bias_width * pe_parallel_weight;
  // one set per array row, array row 0 in the low bits
  localparam int bias_set_4_channel_width = bias_set_width * sa_row_num;

  // memory word feeding the bias file
  localparam int bias_word_length = 512;
  // full 16-bit sets carried by one word
  localparam int sets_per_word = bias_word_length / bias_set_width;

  //////////////////////////////
  // accumulator side
  //////////////////////////////

  localparam int acc_width = 24;
  // slot r*2+l holds array row r, lane l
  localparam int acc_row_width = sa_row_num * pe_parallel_weight * acc_width;

  //////////////////////////////
  // load modes
  //////////////////////////////

  // 64 byte biases, zero-extended into the sets
  localparam logic [3:0] mode_bias8 = 4'd0;
  // 32 full sets into the lower or upper half
  localparam logic [3:0] mode_bias16 = 4'd1;

  // the only start registers a mode 1 load accepts
  localparam int mode16_low_start = 1;
  localparam int mode16_high_start = 1 + sets_per_word;

  // one memory word, read either as bytes or as full sets
  typedef union packed {
    logic [bias_sets_num-1:0][bias_width-1:0] bias8;
    logic [sets_per_word-1:0][bias_set_width-1:0] set16;
  } bias_word_t;

endpackage

`default_nettype wire

/* hdl/bias_regs.sv */
`default_nettype none

module bias_regs (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          bias_set,
  input  logic [3:0]                                    mode,
  input  conv_pkg::bias_word_t                          bias_word,
  input  logic [7:0]                                    bias_reg_start,
  input  logic [7:0]                                    bias_reg_size,
  input  logic [5:0]                                    out_sa_row_idx,
  output logic [conv_pkg::bias_set_4_channel_width-1:0] bias_4_channel_sets
);
  import conv_pkg::*;

  // entry k holds register k+1
  logic [bias_set_width-1:0] bias_tile [bias_sets_num];
  logic [bias_set_width-1:0] load_val  [bias_sets_num];
  logic [bias_sets_num-1:0]  load_mask;
  logic [8:0]                reg_end;
  logic [3:0]                row_off;
  logic                      low_half;
  logic                      high_half;

  //////////////////////////////
  // load range
  //////////////////////////////

  // last register of [start, start+size-1], 9 bits so it cannot wrap
  assign reg_end = {1'b0, bias_reg_start} + {1'b0, bias_reg_size} - 9'd1;

  always_comb begin
    for (int k = 0; k < bias_sets_num; k++) begin
      load_mask[k] = (bias_reg_size != 8'd0) &&
                     (9'(k + 1) >= {1'b0, bias_reg_start}) &&
                     (9'(k + 1) <= reg_end);
    end
  end

  //////////////////////////////
  // word decode
  //////////////////////////////

  assign low_half  = (bias_reg_start == 8'(mode16_low_start));
  assign high_half = (bias_reg_start == 8'(mode16_high_start));

  // anything but a valid mode/start pair clears the selected entries
  always_comb begin
    for (int k = 0; k < bias_sets_num; k++) begin
      load_val[k] = '0;
      case (mode)
        mode_bias8: begin
          load_val[k] = {{(bias_set_width - bias_width){1'b0}}, bias_word.bias8[k]};
        end
        mode_bias16: begin
          if ((low_half && k < sets_per_word) || (high_half && k >= sets_per_word)) begin
            load_val[k] = bias_word.set16[k % sets_per_word];
          end
        end
        default: begin
          load_val[k] = '0;
        end
      endcase
    end
  end

  //////////////////////////////
  // register file
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < bias_sets_num; k++) begin
        bias_tile[k] <= '0;
      end
    end else if (bias_set) begin
      for (int k = 0; k < bias_sets_num; k++) begin
        if (load_mask[k]) begin
          bias_tile[k] <= load_val[k];
        end
      end
    end
  end

  //////////////////////////////
  // read by output row
  //////////////////////////////

  // output rows run 1..16
  assign row_off = 4'(out_sa_row_idx - 6'd1);

  always_comb begin
    bias_4_channel_sets = '0;
    if (out_sa_row_idx != 6'd0) begin
      for (int r = 0; r < sa_row_num; r++) begin
        bias_4_channel_sets[r*bias_set_width +: bias_set_width] =
          bias_tile[r*row_num_in_sa + int'(row_off)];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/bias_apply.sv */
`default_nettype none

module bias_apply (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          row_restart,
  input  logic                                          acc_valid,
  input  logic [conv_pkg::acc_row_width-1:0]            acc_data,
  input  logic [conv_pkg::bias_set_4_channel_width-1:0] bias_4_channel_sets,
  output logic [5:0]                                    out_sa_row_idx,
  output logic                                          out_valid,
  output logic [conv_pkg::acc_row_width-1:0]            out_data
);
  import conv_pkg::*;

  localparam logic [5:0] first_row = 6'd1;
  localparam logic [5:0] last_row  = 6'(row_num_in_sa);

  logic [acc_row_width-1:0] sum_row;
  logic [5:0]               next_row;

  // bias byte widened to the accumulator, keeping its sign
  function automatic logic [acc_width-1:0] sext_bias(input logic [bias_width-1:0] b);
    return {{(acc_width - bias_width){b[bias_width-1]}}, b};
  endfunction

  //////////////////////////////
  // output-row counter
  //////////////////////////////

  // wraps 16 -> 1
  assign next_row = (out_sa_row_idx == last_row) ? first_row : out_sa_row_idx + 6'd1;

  // restart wins over advance, the current drain still uses the old row
  always_ff @(posedge clk) begin
    if (reset) begin
      out_sa_row_idx <= first_row;
    end else if (row_restart) begin
      out_sa_row_idx <= first_row;
    end else if (acc_valid) begin
      out_sa_row_idx <= next_row;
    end
  end

  //////////////////////////////
  // bias add
  //////////////////////////////

  // slot r*2+l takes lane l of the set for array row r
  always_comb begin
    for (int r = 0; r < sa_row_num; r++) begin
      for (int l = 0; l < pe_parallel_weight; l++) begin
        sum_row[(r*pe_parallel_weight + l)*acc_width +: acc_width] =
          acc_data[(r*pe_parallel_weight + l)*acc_width +: acc_width] +
          sext_bias(bias_4_channel_sets[r*bias_set_width + l*bias_width +: bias_width]);
      end
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  // one cycle from acc_valid, data held between strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= acc_valid;
      if (acc_valid) begin
        out_data <= sum_row;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/conv_bias_unit.sv */
`default_nettype none

module conv_bias_unit (
  input  logic                               clk,
  input  logic                               reset,
  // load side
  input  logic                               bias_set,
  input  logic [3:0]                         mode,
  input  conv_pkg::bias_word_t               bias_word,
  input  logic [7:0]                         bias_reg_start,
  input  logic [7:0]                         bias_reg_size,
  // drain side
  input  logic                               row_restart,
  input  logic                               acc_valid,
  input  logic [conv_pkg::acc_row_width-1:0] acc_data,
  output logic                               out_valid,
  output logic [conv_pkg::acc_row_width-1:0] out_data
);
  import conv_pkg::*;

  // current output row, 1..16
  logic [5:0]                          out_sa_row_idx;
  // one bias set per array row for that output row
  logic [bias_set_4_channel_width-1:0] bias_4_channel_sets;

  //////////////////////////////
  // bias register file
  //////////////////////////////

  bias_regs u_bias_regs (
    .clk                 (clk),
    .reset               (reset),
    .bias_set            (bias_set),
    .mode                (mode),
    .bias_word           (bias_word),
    .bias_reg_start      (bias_reg_start),
    .bias_reg_size       (bias_reg_size),
    .out_sa_row_idx      (out_sa_row_idx),
    .bias_4_channel_sets (bias_4_channel_sets)
  );

  //////////////////////////////
  // row counter and adder
  //////////////////////////////

  bias_apply u_bias_apply (
    .clk                 (clk),
    .reset               (reset),
    .row_restart         (row_restart),
    .acc_valid           (acc_valid),
    .acc_data            (acc_data),
    .bias_4_channel_sets (bias_4_channel_sets),
    .out_sa_row_idx      (out_sa_row_idx),
    .out_valid           (out_valid),
    .out_data            (out_data)
  );

endmodule

`default_nettype wire

/* verif/tb_conv_bias_unit.sv */
`default_nettype none

module tb_conv_bias_unit;
  import conv_pkg::*;

  // well above the length of the sequence
  localparam int max_cycles = 2000;

  logic                         clk;
  logic                         reset;
  logic                         bias_set;
  logic [3:0]                   mode;
  logic [bias_word_length-1:0]  bias_word;
  logic [7:0]                   bias_reg_start;
  logic [7:0]                   bias_reg_size;
  logic                         row_restart;
  logic                         acc_valid;
  logic [acc_row_width-1:0]     acc_data;
  logic                         out_valid;
  logic [acc_row_width-1:0]     out_data;

  integer                       seed;
  int                           errors;
  int                           cycle_count;
  // indexed by register number 1..64 as in the load range
  logic [bias_set_width-1:0]    model_regs [1:bias_sets_num];
  int                           model_row;
  logic [acc_row_width-1:0]     exp_q [$];
  logic [acc_row_width-1:0]     exp_data;

  conv_bias_unit uut (
    .clk            (clk),
    .reset          (reset),
    .bias_set       (bias_set),
    .mode           (mode),
    .bias_word      (bias_word),
    .bias_reg_start (bias_reg_start),
    .bias_reg_size  (bias_reg_size),
    .row_restart    (row_restart),
    .acc_valid      (acc_valid),
    .acc_data       (acc_data),
    .out_valid      (out_valid),
    .out_data       (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic [acc_row_width-1:0] random_acc_row();
    logic [acc_row_width-1:0] v;
    for (int i = 0; i < acc_row_width / 32; i++) begin
      v[i*32 +: 32] = $random(seed);
    end
    return v;
  endfunction

  function automatic logic [bias_word_length-1:0] random_word();
    logic [bias_word_length-1:0] v;
    for (int i = 0; i < bias_word_length / 32; i++) begin
      v[i*32 +: 32] = $random(seed);
    end
    return v;
  endfunction

  // load rule applied to the model registers
  function automatic void update_model(input logic [3:0] m, input logic [7:0] start,
                                       input logic [7:0] size,
                                       input logic [bias_word_length-1:0] w);
    int first;
    int last;
    first = int'(start);
    last = int'(start) + int'(size) - 1;
    for (int k = 1; k <= bias_sets_num; k++) begin
      if (k >= first && k <= last) begin
        if (m == mode_bias8) begin
          model_regs[k] = {8'h00, w[(k-1)*8 +: 8]};
        end else if (m == mode_bias16 && (first == 1 || first == 33) && k - first < 32) begin
          model_regs[k] = w[(k-first)*16 +: 16];
        end else begin
          model_regs[k] = 16'h0000;
        end
      end
    end
  endfunction

  function automatic logic [acc_row_width-1:0] expected_sums(
      input logic [acc_row_width-1:0] acc, input int row);
    logic [acc_row_width-1:0]  sums;
    logic [bias_set_width-1:0] set;
    logic [acc_width-1:0]      bias_ext;
    int                        slot;
    for (int r = 0; r < sa_row_num; r++) begin
      set = model_regs[r*row_num_in_sa + row];
      for (int l = 0; l < pe_parallel_weight; l++) begin
        slot = r * pe_parallel_weight + l;
        bias_ext = acc_width'($signed(set[l*bias_width +: bias_width]));
        sums[slot*acc_width +: acc_width] = acc[slot*acc_width +: acc_width] + bias_ext;
      end
    end
    return sums;
  endfunction

  //////////////////////////////
  // drive tasks
  //////////////////////////////

  // strobes last one cycle unless the next call sets them again
  task automatic next_cycle();
    @(posedge clk);
    #10;
    bias_set = 1'b0;
    acc_valid = 1'b0;
    row_restart = 1'b0;
  endtask

  task automatic load_biases(input logic [3:0] m, input logic [7:0] start,
                             input logic [7:0] size,
                             input logic [bias_word_length-1:0] w);
    next_cycle();
    bias_set = 1'b1;
    mode = m;
    bias_word = w;
    bias_reg_start = start;
    bias_reg_size = size;
    update_model(m, start, size, w);
  endtask

  task automatic drain_row(input logic restart);
    logic [acc_row_width-1:0] acc;
    acc = random_acc_row();
    next_cycle();
    acc_valid = 1'b1;
    row_restart = restart;
    acc_data = acc;
    exp_q.push_back(expected_sums(acc, model_row));
    if (restart) begin
      model_row = 1;
    end else begin
      model_row = (model_row == row_num_in_sa) ? 1 : model_row + 1;
    end
  endtask

  task automatic drain_rows(input int n);
    repeat (n) drain_row(1'b0);
  endtask

  task automatic restart_rows();
    next_cycle();
    row_restart = 1'b1;
    model_row = 1;
  endtask

  // wait until every expected row has been checked
  task automatic flush_outputs();
    next_cycle();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    repeat (2) @(posedge clk);
  endtask

  //////////////////////////////
  // checks
  //////////////////////////////

  // pop the head of the queue so it is stable at the next rising edge
  always @(negedge clk) begin
    if (!reset && out_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("out_valid was high with no result expected, cycle %0d", cycle_count);
        exp_data = '0;
      end else begin
        exp_data = exp_q.pop_front();
      end
    end
  end

  valid_follows_acc: assert property (
    @(posedge clk) disable iff (reset) out_valid == $past(acc_valid)
  ) else begin
    errors++;
    $display("[FAIL] out_valid: got %h, expected %h", $sampled(out_valid),
             !$sampled(out_valid));
  end

  data_matches_model: assert property (
    @(posedge clk) disable iff (reset) out_valid |-> (out_data == exp_data)
  ) else begin
    errors++;
    $display("[FAIL] out_data: got %h, expected %h", $sampled(out_data),
             $sampled(exp_data));
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, %0d results still pending", cycle_count,
             exp_q.size());
    $display("Test failed");
    $finish;
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    seed = 32'h3b1553d0;
    errors = 0;
    exp_data = '0;
    model_row = 1;
    for (int k = 1; k <= bias_sets_num; k++) begin
      model_regs[k] = '0;
    end
    reset = 1'b1;
    bias_set = 1'b0;
    mode = 4'd0;
    bias_word = '0;
    bias_reg_start = 8'd0;
    bias_reg_size = 8'd0;
    row_restart = 1'b0;
    acc_valid = 1'b0;
    acc_data = '0;

    repeat (4) @(posedge clk);
    #10;
    reset = 1'b0;
    @(negedge clk);
    assert (out_valid == 1'b0) else begin
      errors++;
      $display("[FAIL] out_valid: got %h, expected %h", out_valid, 1'b0);
    end
    assert (out_data == '0) else begin
      errors++;
      $display("[FAIL] out_data: got %h, expected %h", out_data, {acc_row_width{1'b0}});
    end

    // zero biases pass accumulators through
    drain_rows(16);
    flush_outputs();

    // full byte load leaves lane 1 at zero
    load_biases(mode_bias8, 8'd1, 8'd64, random_word());
    drain_rows(16);
    flush_outputs();

    // both halves as full sets
    load_biases(mode_bias16, 8'd1, 8'd32, random_word());
    load_biases(mode_bias16, 8'd33, 8'd32, random_word());
    drain_rows(16);
    flush_outputs();

    // narrow range and then clears by bad mode and bad start
    load_biases(mode_bias8, 8'd20, 8'd5, random_word());
    drain_rows(16);
    load_biases(4'd2, 8'd40, 8'd10, random_word());
    load_biases(mode_bias16, 8'd5, 8'd3, random_word());
    drain_rows(16);
    flush_outputs();

    // wrap over 16 and restart with and without a drain
    drain_rows(21);
    drain_row(1'b1);
    drain_rows(6);
    restart_rows();
    drain_rows(4);
    flush_outputs();

    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/conv_pkg.sv
hdl/bias_regs.sv
hdl/bias_apply.sv
hdl/conv_bias_unit.sv
verif/tb_conv_bias_unit.sv

/* Makefile */
# Verilator build and run of the bias unit testbench

VERILATOR ?= verilator
TOP       ?= tb_conv_bias_unit
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_TEXT ?= Test completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass when the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass message
test: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
